//--- Bender.yml
package:
  name: poly_actor

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/poly_pkg.sv
      - verilog/cmd_decode.sv
      - verilog/coef_store.sv
      - verilog/poly_exec.sv
      - verilog/result_emit.sv
      - verilog/firing_ctrl.sv
      - verilog/poly_actor.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_poly_actor.sv

//--- files.f
+incdir+verilog
verilog/poly_pkg.sv
verilog/cmd_decode.sv
verilog/coef_store.sv
verilog/poly_exec.sv
verilog/result_emit.sv
verilog/firing_ctrl.sv
verilog/poly_actor.sv
testbench/tb_poly_actor.sv

//--- testbench/tb_poly_actor.sv
/* Testbench for the polynomial actor.
   Random commands checked against a reference model, with throttled FIFO models. */
`timescale 1ns/1ps
`include "poly_config.svh"

module tb_poly_actor
   import poly_pkg::*;
();

   localparam int N_RAND      = 60;
   localparam int N_FIRINGS   = 1 + 16 + 4 + 4 + 16 + 2 * N_RAND;
   localparam int CYCLE_LIMIT = N_FIRINGS * 400;

   logic                    clk, rst, start, done;
   fire_mode_e              mode;
   logic [`POLY_WORD_W-1:0] cmd_word, data_word;
   logic                    cmd_avail, cmd_rd, data_avail, data_rd;
   logic [`POLY_RES_W-1:0]  result_word;
   logic                    result_wr, status_wr;
   status_t                 status_word;

   logic [`POLY_WORD_W-1:0] cmd_q[$];   // Command FIFO contents.
   logic [`POLY_WORD_W-1:0] data_q[$];  // Data FIFO contents.
   logic [`POLY_RES_W-1:0]  exp_res_q[$];
   status_t                 exp_status;
   bit                      status_id_known;
   bit                      in_instr;
   int                      cycles = 0;
   int                      done_cnt = 0;
   int                      status_cnt = 0;
   int                      data_reads = 0;
   int                      cmd_reads = 0;
   integer                  seed = 32'h2d4d;

   // Reference model state.
   logic [`POLY_WORD_W-1:0] coef [`POLY_COUNT][`POLY_MAX_DEG+1];
   idx_t                    deg  [`POLY_COUNT];
   bit   [`POLY_COUNT-1:0]  valid = '0;
   cmd_t                    cur;
   bit                      have_cmd = 1'b0;

   poly_actor UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_result(input logic [`POLY_RES_W-1:0] got,
                               input logic [`POLY_RES_W-1:0] exp);
      if (got !== exp)
         stop_run($sformatf("mismatch at %0t: result_word got %h expected %h",
                            $time, got, exp));
   endtask

   task automatic check_status(input status_t got, input status_t exp, input bit with_id);
      bit bad;
      bad = got.err !== exp.err || got.emitted !== exp.emitted || got.rsvd !== exp.rsvd;
      if (with_id && (got.op !== exp.op || got.poly_id !== exp.poly_id))
         bad = 1'b1; // Op and id are unknown before the first SETUP.
      if (bad)
         stop_run($sformatf("mismatch at %0t: status_word got %h expected %h",
                            $time, got, exp));
   endtask

   // Horner's rule, c0 is the highest power.
   function automatic logic [`POLY_RES_W-1:0] horner(input int id,
                                                      input logic [`POLY_WORD_W-1:0] x);
      logic [`POLY_RES_W-1:0] acc;
      acc = '0;
      for (int i = 0; i <= int'(deg[id]); i++)
         acc = acc * x + coef[id][i];
      return acc;
   endfunction

   function automatic cmd_t make_cmd(input opcode_e op, input int id, input int count);
      cmd_t c;
      c.op      = op;
      c.poly_id = poly_id_t'(id);
      c.count   = idx_t'(count);
      c.rsvd    = 7'($random(seed)); // Reserved bits must be ignored.
      return c;
   endfunction

   // One cycle of FIFO drive on the falling edge.
   task automatic step();
      @(negedge clk);
      cmd_avail  = cmd_q.size() > 0 && ($random(seed) & 3) != 0;
      cmd_word   = (cmd_q.size() > 0) ? cmd_q[0] : '0;
      data_avail = data_q.size() > 0 && ($random(seed) & 3) != 0;
      data_word  = (data_q.size() > 0) ? data_q[0] : '0;
   endtask

   task automatic fire(input fire_mode_e m);
      int done_before;
      done_before = done_cnt;
      in_instr    = (m == INSTR);
      step();
      start = 1'b1;
      mode  = m;
      step();
      start = 1'b0;
      while (done_cnt == done_before)
         step();
      repeat (2)
         step();
      if (done_cnt != done_before + 1)
         stop_run($sformatf("firing gave %0d done pulses", done_cnt - done_before));
   endtask

   task automatic setup_cmd(input cmd_t c);
      int reads_before;
      int status_before;
      reads_before  = cmd_reads;
      status_before = status_cnt;
      cmd_q.push_back(c);
      fire(SETUP);
      if (cmd_reads != reads_before + 1 || cmd_q.size() != 0)
         stop_run("SETUP firing did not read exactly one command word");
      if (status_cnt != status_before)
         stop_run("SETUP firing wrote a status word");
      cur      = c;
      have_cmd = 1'b1;
   endtask

   task automatic exec_cmd();
      err_e                    err;
      int                      n_data;
      int                      n_res;
      int                      reads_before;
      int                      status_before;
      logic [`POLY_WORD_W-1:0] w;
      n_data = 0;
      n_res  = 0;
      if (!have_cmd)
         err = NO_CMD;
      else if ((cur.op == STP && cur.count > `POLY_MAX_DEG) || (cur.op == EVB && cur.count == 0))
         err = BAD_COUNT;
      else if ((cur.op == EVP || cur.op == EVB) && !valid[cur.poly_id])
         err = UNSET;
      else
         err = OK;
      if (err == OK)
      begin
         case (cur.op)
            STP:
            begin
               for (int i = 0; i <= int'(cur.count); i++)
               begin
                  w = $random(seed);
                  data_q.push_back(w);
                  coef[cur.poly_id][i] = w;
                  n_data++;
               end
               deg[cur.poly_id]   = cur.count;
               valid[cur.poly_id] = 1'b1;
            end
            EVP, EVB:
               for (int i = 0; i < ((cur.op == EVP) ? 1 : int'(cur.count)); i++)
               begin
                  w = $random(seed);
                  data_q.push_back(w);
                  exp_res_q.push_back(horner(cur.poly_id, w));
                  n_data++;
                  n_res++;
               end
            default:
               valid = '0;
         endcase
      end
      data_q.push_back(16'($random(seed))); // Spare word that must stay unread.
      exp_status.op      = cur.op;
      exp_status.poly_id = cur.poly_id;
      exp_status.err     = err;
      exp_status.emitted = emit_cnt_t'(n_res);
      exp_status.rsvd    = '0;
      status_id_known    = have_cmd;
      reads_before       = data_reads;
      status_before      = status_cnt;
      fire(INSTR);
      if (exp_res_q.size() != 0)
         stop_run($sformatf("%0d expected results never came", exp_res_q.size()));
      if (status_cnt != status_before + 1)
         stop_run("INSTR firing did not write exactly one status word");
      if (data_reads - reads_before != n_data || data_q.size() != 1)
         stop_run($sformatf("INSTR firing read %0d data words, %0d expected",
                            data_reads - reads_before, n_data));
      data_q.delete();
   endtask

   task automatic run_cmd(input cmd_t c);
      setup_cmd(c);
      exec_cmd();
   endtask

   task automatic random_cmd();
      int pick;
      int id;
      pick = $unsigned($random(seed)) % 16;
      id   = $unsigned($random(seed)) % `POLY_COUNT;
      if (pick == 0)
         run_cmd(make_cmd(RST, id, 0));
      else if (pick == 1)
         run_cmd(make_cmd(STP, id, `POLY_MAX_DEG + 1 + $unsigned($random(seed)) % 5));
      else if (pick == 2)
         run_cmd(make_cmd(EVB, id, 0));
      else if (pick < 7)
         run_cmd(make_cmd(STP, id, $unsigned($random(seed)) % (`POLY_MAX_DEG + 1)));
      else if (pick < 11)
         run_cmd(make_cmd(EVP, id, 0));
      else
         run_cmd(make_cmd(EVB, id, 1 + $unsigned($random(seed)) % 15));
   endtask

   // Outputs are sampled at the rising edge, before the DUT registers update.
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
         stop_run($sformatf("timeout: run exceeded %0d cycles", CYCLE_LIMIT));
      if (rst)
      begin
         if (cmd_rd)
         begin
            if (cmd_q.size() == 0)
               stop_run("command read from an empty FIFO");
            void'(cmd_q.pop_front());
            cmd_reads++;
         end
         if (data_rd)
         begin
            if (data_q.size() == 0)
               stop_run("data read from an empty FIFO");
            void'(data_q.pop_front());
            data_reads++;
         end
         if (result_wr)
         begin
            if (exp_res_q.size() == 0)
               stop_run("result written when none was expected");
            check_result(result_word, exp_res_q.pop_front());
         end
         if (status_wr)
         begin
            check_status(status_word, exp_status, status_id_known);
            status_cnt++;
         end
         if (status_wr && !done)
            stop_run("status written outside the done cycle");
         if (done && in_instr && !status_wr)
            stop_run("INSTR firing ended without a status word");
         if (done)
            done_cnt++;
      end
   end

   initial
   begin
      rst        = 1'b0;
      start      = 1'b0;
      mode       = SETUP;
      cmd_word   = '0;
      cmd_avail  = 1'b0;
      data_word  = '0;
      data_avail = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;
      exec_cmd(); // No command decoded yet.
      for (int i = 0; i < `POLY_COUNT; i++)
         run_cmd(make_cmd(STP, i, $unsigned($random(seed)) % (`POLY_MAX_DEG + 1)));
      run_cmd(make_cmd(RST, 0, 0));
      run_cmd(make_cmd(EVP, 3, 0));
      run_cmd(make_cmd(STP, 5, `POLY_MAX_DEG + 1));
      run_cmd(make_cmd(EVB, 2, 0)); // Count error wins over unset.
      for (int i = 0; i < `POLY_COUNT; i++)
         run_cmd(make_cmd(STP, i, $unsigned($random(seed)) % (`POLY_MAX_DEG + 1)));
      for (int n = 0; n < N_RAND; n++)
         random_cmd();
      $display("Everything OK");
      $finish;
   end

endmodule

//--- verilog/cmd_decode.sv
/* Command decoder.
   Takes one word from the command FIFO and holds it with its count check. */
`timescale 1ns/1ps
`include "poly_config.svh"

module cmd_decode
   import poly_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    go,
   input  logic [`POLY_WORD_W-1:0] cmd_word,
   input  logic                    cmd_avail,
   output logic                    cmd_rd,
   output cmd_t                    cmd,
   output logic                    cmd_valid,
   output logic                    bad_count,
   output logic                    decode_done
);

   logic busy;
   cmd_t word_in;

   assign word_in = cmd_t'(cmd_word);
   assign cmd_rd  = busy && cmd_avail; // Consume as soon as a word is there.

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         busy        <= 1'b0;
         cmd_valid   <= 1'b0;
         decode_done <= 1'b0;
      end
      else
      begin
         decode_done <= cmd_rd;
         if (go)
            busy <= 1'b1;
         else if (cmd_rd)
            busy <= 1'b0;
         if (cmd_rd)
            cmd_valid <= 1'b1; // Stays set until reset.
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmd_rd)
      begin
         cmd       <= word_in;
         bad_count <= (word_in.op == STP && word_in.count > `POLY_MAX_DEG) ||
                      (word_in.op == EVB && word_in.count == '0);
      end
   end

   // A new decode only starts once the last one has read its word.
   assert property (@(posedge clk) disable iff (!rst)
      go |-> !busy);

endmodule

//--- verilog/coef_store.sv
/* Coefficient store.
   Coefficients of every polynomial plus a degree and valid table. */
`timescale 1ns/1ps
`include "poly_config.svh"

module coef_store
   import poly_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wr_en,
   input  poly_id_t                wr_id,
   input  idx_t                    wr_idx,
   input  logic [`POLY_WORD_W-1:0] wr_data,
   input  logic                    set_deg,
   input  idx_t                    deg_in,
   input  logic                    clear_all,
   input  poly_id_t                rd_id,
   input  idx_t                    rd_idx,
   output logic [`POLY_WORD_W-1:0] rd_data,
   output idx_t                    deg,
   output logic                    deg_valid
);

   logic [`POLY_WORD_W-1:0] coef_mem [`POLY_COUNT][`POLY_MAX_DEG+1];
   idx_t                    deg_tab  [`POLY_COUNT];
   logic [`POLY_COUNT-1:0]  valid_tab;

   always_ff @(posedge clk)
   begin
      if (wr_en)
         coef_mem[wr_id][wr_idx] <= wr_data;
      if (set_deg)
         deg_tab[wr_id] <= deg_in;
      rd_data <= coef_mem[rd_id][rd_idx]; // Data one cycle after address.
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         valid_tab <= '0;
      else if (clear_all)
         valid_tab <= '0; // RST command.
      else if (set_deg)
         valid_tab[wr_id] <= 1'b1;
   end

   assign deg       = deg_tab[rd_id];
   assign deg_valid = valid_tab[rd_id];

   assert property (@(posedge clk) disable iff (!rst)
      wr_en |-> wr_idx <= `POLY_MAX_DEG);

endmodule

//--- verilog/firing_ctrl.sv
/* Firing controller.
   Sequences decode or execute for each start pulse and answers with done. */
`timescale 1ns/1ps

module firing_ctrl
   import poly_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       start,
   input  fire_mode_e mode,
   input  logic       decode_done,
   input  logic       fire_done,
   output logic       decode_go,
   output logic       exec_go,
   output logic       done
);

   typedef enum logic [1:0] {IDLE, DECODE, EXEC, FINISH} state_e;

   state_e state;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state     <= IDLE;
         decode_go <= 1'b0;
         exec_go   <= 1'b0;
      end
      else
      begin
         decode_go <= 1'b0;
         exec_go   <= 1'b0;
         case (state)
            IDLE:
               if (start && mode == SETUP)
               begin
                  decode_go <= 1'b1;
                  state     <= DECODE;
               end
               else if (start && mode == INSTR)
               begin
                  exec_go <= 1'b1;
                  state   <= EXEC;
               end
            DECODE:
               if (decode_done)
                  state <= FINISH;
            EXEC:
               if (fire_done)
                  state <= IDLE;
            FINISH:
               state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   // INSTR done lines up with the status strobe.
   assign done = (state == FINISH) || (state == EXEC && fire_done);

   // The decoder only answers a decode that was started here.
   assert property (@(posedge clk) disable iff (!rst)
      decode_done |-> state == DECODE);

   // The output stage only finishes a firing that was started here.
   assert property (@(posedge clk) disable iff (!rst)
      fire_done |-> state == EXEC);

endmodule

//--- verilog/poly_actor.sv
/* Polynomial evaluation actor.
   Top level joining control, decode, store, execute and output stages. */
`timescale 1ns/1ps
`include "poly_config.svh"

module poly_actor
   import poly_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start,
   input  fire_mode_e              mode,
   output logic                    done,
   input  logic [`POLY_WORD_W-1:0] cmd_word,
   input  logic                    cmd_avail,
   output logic                    cmd_rd,
   input  logic [`POLY_WORD_W-1:0] data_word,
   input  logic                    data_avail,
   output logic                    data_rd,
   output logic [`POLY_RES_W-1:0]  result_word,
   output logic                    result_wr,
   output status_t                 status_word,
   output logic                    status_wr
);

   logic decode_go, exec_go, decode_done, fire_done;
   cmd_t cmd;
   logic cmd_valid, bad_count;

   logic                    wr_en, set_deg, clear_all, deg_valid;
   poly_id_t                wr_id, rd_id;
   idx_t                    wr_idx, rd_idx, deg_in, deg;
   logic [`POLY_WORD_W-1:0] wr_data, rd_data;

   exec_out_t exec_out;
   logic      exec_out_en;

   firing_ctrl u_ctrl (.*);

   cmd_decode u_decode (.go(decode_go), .*);

   coef_store u_store (.*);

   poly_exec u_exec (.go(exec_go), .*);

   result_emit u_emit (.*);

endmodule

//--- verilog/poly_config.svh
/* Polynomial actor configuration.
   Word widths, table sizes and limits shared by the design. */
`ifndef POLY_CONFIG_SVH
`define POLY_CONFIG_SVH

`define POLY_WORD_W   16 // Data and command words.
`define POLY_RES_W    32 // Result and status words.

`define POLY_COUNT    8  // Stored polynomials.
`define POLY_MAX_DEG  10 // Highest degree, 11 coefficients.

`define POLY_ID_W     3  // Polynomial select.
`define POLY_IDX_W    4  // Degree, block length and coefficient index.

`endif

//--- verilog/poly_exec.sv
/* Command execution.
   Runs STP, EVP, EVB and RST and evaluates polynomials with Horner's rule. */
`timescale 1ns/1ps
`include "poly_config.svh"

module poly_exec
   import poly_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic go,
   input  cmd_t cmd,
   input  logic cmd_valid,
   input  logic bad_count,
   input  logic [`POLY_WORD_W-1:0] data_word,
   input  logic data_avail,
   output logic data_rd,
   output logic wr_en,
   output poly_id_t wr_id,
   output idx_t wr_idx,
   output logic [`POLY_WORD_W-1:0] wr_data,
   output logic set_deg,
   output idx_t deg_in,
   output logic clear_all,
   output poly_id_t rd_id,
   output idx_t rd_idx,
   input  logic [`POLY_WORD_W-1:0] rd_data,
   input  idx_t deg,
   input  logic deg_valid,
   output exec_out_t exec_out,
   output logic exec_out_en
);

   localparam int PAD = `POLY_RES_W - `POLY_WORD_W;

   typedef enum logic [2:0] {IDLE, LOAD, GET_X, FETCH, MAC} state_e;

   state_e                  state;
   idx_t                    idx;       // Coefficient index.
   idx_t                    remaining; // x values still to evaluate.
   logic [`POLY_WORD_W-1:0] x;
   logic [`POLY_RES_W-1:0]  acc;
   logic [`POLY_RES_W-1:0]  mac_val;
   logic                    take_x;
   err_e                    go_err;

   always_comb
   begin
      if (!cmd_valid)
         go_err = NO_CMD;
      else if (bad_count)
         go_err = BAD_COUNT;
      else if ((cmd.op == EVP || cmd.op == EVB) && !deg_valid)
         go_err = UNSET;
      else
         go_err = OK;
   end

   assign take_x    = state == GET_X && data_avail;
   assign data_rd   = data_avail && (state == LOAD || state == GET_X);
   assign wr_en     = state == LOAD && data_avail;
   assign set_deg   = wr_en && idx == cmd.count; // Last coefficient makes it valid.
   assign clear_all = state == IDLE && go && go_err == OK && cmd.op == RST;
   assign wr_id     = cmd.poly_id;
   assign rd_id     = cmd.poly_id;
   assign wr_idx    = idx;
   assign rd_idx    = idx;
   assign wr_data   = data_word;
   assign deg_in    = cmd.count;
   assign mac_val   = acc * {{PAD{1'b0}}, x} + {{PAD{1'b0}}, rd_data};

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state       <= IDLE;
         idx         <= '0;
         remaining   <= '0;
         exec_out_en <= 1'b0;
      end
      else
      begin
         exec_out_en <= 1'b0;
         case (state)
            IDLE:
               if (go)
               begin
                  idx       <= '0;
                  remaining <= (cmd.op == EVB) ? cmd.count : idx_t'(1);
                  if (go_err != OK || cmd.op == RST)
                     exec_out_en <= 1'b1; // Status only.
                  else if (cmd.op == STP)
                     state <= LOAD;
                  else
                     state <= GET_X;
               end
            LOAD:
               if (data_avail)
               begin
                  idx <= idx + 1'b1;
                  if (idx == cmd.count)
                  begin
                     exec_out_en <= 1'b1;
                     state       <= IDLE;
                  end
               end
            GET_X:
               if (data_avail)
               begin
                  idx   <= '0;
                  state <= FETCH;
               end
            FETCH:
               state <= MAC; // Wait for the store read.
            MAC:
               if (idx == deg)
               begin
                  exec_out_en <= 1'b1;
                  remaining   <= remaining - 1'b1;
                  state       <= (remaining == idx_t'(1)) ? IDLE : GET_X;
               end
               else
               begin
                  idx   <= idx + 1'b1;
                  state <= FETCH;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (take_x)
      begin
         x   <= data_word;
         acc <= '0;
      end
      else if (state == MAC)
         acc <= mac_val;
      if (state == MAC)
      begin
         exec_out.value     <= mac_val;
         exec_out.err       <= OK;
         exec_out.has_value <= 1'b1;
         exec_out.last      <= remaining == idx_t'(1);
      end
      else
      begin
         exec_out.value     <= '0;
         exec_out.err       <= go_err; // OK at the end of STP.
         exec_out.has_value <= 1'b0;
         exec_out.last      <= 1'b1;
      end
   end

   // Data is only read for a decoded command that passed the count check.
   assert property (@(posedge clk) disable iff (!rst)
      data_rd |-> cmd_valid && !bad_count);

endmodule

//--- verilog/poly_pkg.sv
/* Polynomial actor package.
   Command, status and execute-path types. */
`include "poly_config.svh"

package poly_pkg;

   typedef logic [`POLY_ID_W-1:0]  poly_id_t;
   typedef logic [`POLY_IDX_W-1:0] idx_t;
   typedef logic [4:0]             emit_cnt_t;

   typedef enum logic [1:0] {STP, EVP, EVB, RST} opcode_e;

   typedef enum logic [1:0] {SETUP = 2'd0, INSTR = 2'd1} fire_mode_e;

   typedef enum logic [1:0] {OK, UNSET, BAD_COUNT, NO_CMD} err_e;

   // Command word as read from the command FIFO.
   typedef struct packed {
      opcode_e    op;
      poly_id_t   poly_id;
      idx_t       count;   // Degree for STP, block length for EVB.
      logic [6:0] rsvd;
   } cmd_t;

   typedef struct packed {
      opcode_e     op;
      poly_id_t    poly_id;
      err_e        err;
      emit_cnt_t   emitted; // Results given in this firing.
      logic [19:0] rsvd;
   } status_t;

   // One item from execute to the output stage.
   typedef struct packed {
      logic [`POLY_RES_W-1:0] value;
      err_e                   err;
      logic                   has_value; // Clear for status-only items.
      logic                   last;      // Final item of the firing.
   } exec_out_t;

endpackage

//--- verilog/result_emit.sv
/* Result stage.
   Drives result and status strobes and counts results per firing. */
`timescale 1ns/1ps
`include "poly_config.svh"

module result_emit
   import poly_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst,
   input  exec_out_t              exec_out,
   input  logic                   exec_out_en,
   input  cmd_t                   cmd,
   output logic [`POLY_RES_W-1:0] result_word,
   output logic                   result_wr,
   output status_t                status_word,
   output logic                   status_wr,
   output logic                   fire_done
);

   emit_cnt_t emit_cnt;
   emit_cnt_t next_cnt;

   assign next_cnt  = emit_cnt + emit_cnt_t'(exec_out.has_value);
   assign fire_done = status_wr; // Status closes every INSTR firing.

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         result_wr <= 1'b0;
         status_wr <= 1'b0;
         emit_cnt  <= '0;
      end
      else
      begin
         result_wr <= exec_out_en && exec_out.has_value;
         status_wr <= exec_out_en && exec_out.last;
         if (exec_out_en)
            emit_cnt <= exec_out.last ? '0 : next_cnt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (exec_out_en && exec_out.has_value)
         result_word <= exec_out.value;
      if (exec_out_en && exec_out.last)
      begin
         status_word.op      <= cmd.op;
         status_word.poly_id <= cmd.poly_id;
         status_word.err     <= exec_out.err;
         status_word.emitted <= next_cnt; // Includes a value on this item.
         status_word.rsvd    <= '0;
      end
   end

endmodule
